/* hw/aluPkg.sv */
package aluPkg;

    localparam int wordBits  = 32;      // Operand and result width
    localparam int funcBits  = 6;       // MIPS funct field
    localparam int adrBits   = 3;       // Word address inside the slave
    localparam int shamtBits = 5;       // Variable shift amount taken from A
    localparam int countBits = 6;       // Leading count range 0 to 32
    localparam int numPorts  = 2;       // Master ports on the shared ALU

    typedef logic [wordBits-1:0]         aluWord;
    typedef logic [adrBits-1:0]          regAddr;
    typedef logic [$clog2(numPorts)-1:0] portId;

    // Function codes keep the reference encodings
    typedef enum logic [funcBits-1:0] {
        funcSll  = 6'b000000,
        funcSrl  = 6'b000010,
        funcSra  = 6'b000011,
        funcSllv = 6'b000100,
        funcSrlv = 6'b000110,
        funcSrav = 6'b000111,
        funcMovz = 6'b001010,
        funcMovn = 6'b001011,
        funcGtz  = 6'b001101,
        funcGt   = 6'b001111,
        funcClo  = 6'b011100,
        funcClz  = 6'b011101,
        funcEq   = 6'b011111,
        funcAdd  = 6'b100000,
        funcAddu = 6'b100001,
        funcSub  = 6'b100010,
        funcSubu = 6'b100011,
        funcAnd  = 6'b100100,
        funcOr   = 6'b100101,
        funcXor  = 6'b100110,
        funcNor  = 6'b100111,
        funcSlt  = 6'b101010,
        funcSltu = 6'b101011,
        funcMov  = 6'b111111
    } aluFunc;

    // Slave register map
    localparam regAddr regOpA     = 3'd0;   // Read/write
    localparam regAddr regOpB     = 3'd1;   // Read/write
    localparam regAddr regFunc    = 3'd2;   // Read/write
    localparam regAddr regResult  = 3'd3;   // Read only
    localparam regAddr regFlags   = 3'd4;   // Read only

    // First member lands in bit 4 when read back
    typedef struct packed {
        logic cond;
        logic overflow;
        logic carry;
        logic negative;
        logic zero;
    } aluFlags;

    // Wishbone classic request from a master
    typedef struct packed {
        logic   cyc;
        logic   stb;
        logic   we;
        regAddr adr;
        aluWord dat;
    } wbReq;

    // Wishbone classic response from the slave
    typedef struct packed {
        logic   ack;
        aluWord dat;
    } wbRsp;

endpackage

/* hw/leadCount.sv */
`timescale 1ns/1ps

module leadCount
    import aluPkg::*;
(
    input  logic                 clo,      // 1 counts ones, 0 counts zeros
    input  aluWord               value,
    output logic [countBits-1:0] count
);

    logic found;    // First differing bit already seen

    // Priority scan from the MSB down
    always_comb
    begin
        count = countBits'(wordBits);  // All bits match
        found = 1'b0;
        for (int i = wordBits - 1; i >= 0; i--)
        begin
            if (!found && (value[i] != clo))
            begin
                // Bits above i all matched
                count = countBits'(wordBits - 1 - i);
                found = 1'b1;
            end
        end
    end

endmodule

/* hw/aluCore.sv */
`timescale 1ns/1ps

module aluCore
    import aluPkg::*;
(
    input  aluWord  opA,
    input  aluWord  opB,
    input  aluFunc  func,
    output aluWord  result,
    output aluFlags flags
);

    logic [wordBits:0]    sumExt;     // A + B with carry out on top
    logic [wordBits:0]    diffExt;    // A - B with borrow on top
    logic [shamtBits-1:0] shamt;
    logic [countBits-1:0] leadCnt;
    logic                 countOnes;
    logic                 carry;
    logic                 overflow;
    logic                 cond;

    assign sumExt  = {1'b0, opA} + {1'b0, opB};
    assign diffExt = {1'b0, opA} - {1'b0, opB};
    assign shamt   = opA[shamtBits-1:0];   // MIPS style variable amount

    // One counter shared by CLO and CLZ
    assign countOnes = (func == funcClo);

    leadCount leadCount_i (
        .clo   (countOnes),
        .value (opA),
        .count (leadCnt)
    );

    always_comb
    begin
        result   = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        cond     = 1'b0;
        case (func)
            // Logic
            funcAnd: result = opA & opB;
            funcOr:  result = opA | opB;
            funcXor: result = opA ^ opB;
            funcNor: result = ~(opA | opB);

            // Add and subtract
            funcAdd, funcAddu:
            begin
                result   = sumExt[wordBits-1:0];
                carry    = sumExt[wordBits];
                // Same input signs and result sign flipped
                overflow = (opA[wordBits-1] == opB[wordBits-1])
                        && (result[wordBits-1] != opA[wordBits-1]);
            end
            funcSub, funcSubu:
            begin
                result   = diffExt[wordBits-1:0];
                carry    = diffExt[wordBits];  // Borrow
                overflow = (opA[wordBits-1] != opB[wordBits-1])
                        && (result[wordBits-1] != opA[wordBits-1]);
            end

            // Compares return the truth in bit 0
            funcSlt:
            begin
                cond   = $signed(opA) < $signed(opB);
                result = aluWord'(cond);
            end
            funcSltu:
            begin
                cond   = opA < opB;
                result = aluWord'(cond);
            end
            funcEq:
            begin
                cond   = (opA == opB);
                result = aluWord'(cond);
            end
            funcGt:
            begin
                cond   = $signed(opA) > $signed(opB);
                result = aluWord'(cond);
            end
            funcGtz:
            begin
                cond   = $signed(opA) > 0;
                result = aluWord'(cond);
            end

            // Shifts act on B
            funcSll:  result = opB << 1;
            funcSrl:  result = opB >> 1;
            funcSra:  result = aluWord'($signed(opB) >>> 1);
            funcSllv: result = opB << shamt;
            funcSrlv: result = opB >> shamt;
            funcSrav: result = aluWord'($signed(opB) >>> shamt);

            // Moves
            funcMov:  result = opA;
            funcMovn:
            begin
                cond   = (opB != '0);
                result = cond ? opA : '0;
            end
            funcMovz:
            begin
                cond   = (opB == '0);
                result = cond ? opA : '0;
            end

            funcClo, funcClz: result = aluWord'(leadCnt);

            default: result = '0;   // Unknown code
        endcase
    end

    // Zero and negative follow the result for every code
    assign flags = '{
        cond:     cond,
        overflow: overflow,
        carry:    carry,
        negative: result[wordBits-1],
        zero:     (result == '0)
    };

endmodule

/* hw/wbArbiter.sv */
`timescale 1ns/1ps

module wbArbiter
    import aluPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  wbReq  req0,
    input  wbReq  req1,
    output wbRsp  rsp0,
    output wbRsp  rsp1,
    output wbReq  busReq,
    input  wbRsp  busRsp,
    output portId owner
);

    typedef enum logic {idle, owned} arbState;

    arbState state;
    portId   lastOwner;    // Owner of the previous tenure
    portId   pick;         // Round robin choice

    // Tie goes to the port that was not served last
    always_comb
    begin
        if (req0.cyc && req1.cyc)
            pick = ~lastOwner;
        else if (req1.cyc)
            pick = 1'b1;
        else
            pick = 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= idle;
            owner     <= 1'b0;
            lastOwner <= 1'b1;   // Port 0 wins the first tie
        end
        else
        begin
            case (state)
                idle:
                    if (req0.cyc || req1.cyc)
                    begin
                        state <= owned;
                        owner <= pick;  // Registered grant
                    end
                owned:
                    if (!busReq.cyc)   // Owner released the bus
                    begin
                        state     <= idle;
                        lastOwner <= owner;
                    end
                default: state <= idle;
            endcase
        end
    end

    // Route the owner's request
    always_comb
    begin
        busReq = (owner == 1'b0) ? req0 : req1;
        if (state == idle)
        begin
            busReq.cyc = 1'b0;
            busReq.stb = 1'b0;
        end
    end

    // Only the owner sees the response
    always_comb
    begin
        rsp0 = '0;
        rsp1 = '0;
        if (state == owned)
        begin
            if (owner == 1'b0)
                rsp0 = busRsp;
            else
                rsp1 = busRsp;
        end
    end

endmodule

/* hw/aluRegSlave.sv */
`timescale 1ns/1ps

module aluRegSlave
    import aluPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  wbReq    busReq,
    input  portId   owner,
    output wbRsp    busRsp,
    output aluWord  opA,
    output aluWord  opB,
    output aluFunc  func,
    input  aluWord  result,
    input  aluFlags flags
);

    // One operand bank per master
    aluWord bankA [numPorts];
    aluWord bankB [numPorts];
    aluFunc bankF [numPorts];

    logic   ack;
    logic   xfer;       // New transfer this cycle
    aluWord rdMux;
    aluWord rdData;     // Held with ack

    assign xfer = busReq.cyc && busReq.stb && !ack;

    // Owner's bank feeds the core
    assign opA  = bankA[owner];
    assign opB  = bankB[owner];
    assign func = bankF[owner];

    // Read data select
    always_comb
    begin
        case (busReq.adr)
            regOpA:    rdMux = bankA[owner];
            regOpB:    rdMux = bankB[owner];
            regFunc:   rdMux = aluWord'(bankF[owner]);
            regResult: rdMux = result;
            regFlags:  rdMux = aluWord'(flags);   // Zero extended
            default:   rdMux = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ack <= 1'b0;
            for (int i = 0; i < numPorts; i++)
            begin
                bankA[i] <= '0;
                bankB[i] <= '0;
                bankF[i] <= aluFunc'('0);
            end
        end
        else
        begin
            ack <= xfer;   // One cycle pulse per transfer
            if (xfer && busReq.we)
            begin
                case (busReq.adr)
                    regOpA:  bankA[owner] <= busReq.dat;
                    regOpB:  bankB[owner] <= busReq.dat;
                    regFunc: bankF[owner] <= aluFunc'(busReq.dat[funcBits-1:0]);
                    default: ;   // Result and flags are read only
                endcase
            end
        end
    end

    // Capture read data on the ack edge
    always_ff @(posedge clk)
    begin
        if (xfer)
            rdData <= rdMux;
    end

    assign busRsp = '{ack: ack, dat: rdData};

endmodule

/* hw/aluSubsys.sv */
`timescale 1ns/1ps

module aluSubsys
    import aluPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  wbReq port0Req,
    input  wbReq port1Req,
    output wbRsp port0Rsp,
    output wbRsp port1Rsp
);

    wbReq    busReq;      // Routed request
    wbRsp    busRsp;
    portId   owner;
    aluWord  opA;
    aluWord  opB;
    aluFunc  func;
    aluWord  result;
    aluFlags flags;

    // Two masters share one slave
    wbArbiter wbArbiter_i (
        .clk    (clk),
        .rst    (rst),
        .req0   (port0Req),
        .req1   (port1Req),
        .rsp0   (port0Rsp),
        .rsp1   (port1Rsp),
        .busReq (busReq),
        .busRsp (busRsp),
        .owner  (owner)
    );

    aluRegSlave aluRegSlave_i (
        .clk    (clk),
        .rst    (rst),
        .busReq (busReq),
        .owner  (owner),
        .busRsp (busRsp),
        .opA    (opA),
        .opB    (opB),
        .func   (func),
        .result (result),
        .flags  (flags)
    );

    // Pure combinational execute
    aluCore aluCore_i (
        .opA    (opA),
        .opB    (opB),
        .func   (func),
        .result (result),
        .flags  (flags)
    );

endmodule

/* tb/aluSubsys_chk.sv */
`timescale 1ns/1ps

module aluSubsysChk
    import aluPkg::*;
(
    input logic  clk,
    input logic  rst,
    input wbReq  req0,      // Port 0 request
    input wbReq  req1,      // Port 1 request
    input wbRsp  busRsp,    // Slave response
    input portId owner,
    input wbRsp  rsp0,
    input wbRsp  rsp1
);

    logic ownerCyc;    // cyc of the port holding the grant

    assign ownerCyc = (owner == 1'b0) ? req0.cyc : req1.cyc;

    // Ack is a single cycle pulse
    ackPulse: assert property (@(posedge clk) disable iff (rst)
        busRsp.ack |=> !busRsp.ack)
    else $error("Slave ack stayed high for two cycles");

    // Ack only at the owning port with its request open
    ackOwner0: assert property (@(posedge clk) disable iff (rst)
        rsp0.ack |-> (owner == 1'b0) && req0.cyc && req0.stb)
    else $error("Port 0 saw ack without owning the bus");

    ackOwner1: assert property (@(posedge clk) disable iff (rst)
        rsp1.ack |-> (owner == 1'b1) && req1.cyc && req1.stb)
    else $error("Port 1 saw ack without owning the bus");

    // Grant stays while the owning port keeps cyc up
    // A request raised in idle has no high past sample
    ownerHold: assert property (@(posedge clk) disable iff (rst)
        (ownerCyc && $past(ownerCyc)) |=> $stable(owner))
    else $error("Owner changed while the owning port held cyc");

endmodule

bind aluSubsys aluSubsysChk aluSubsysChk_i (
    .clk    (clk),
    .rst    (rst),
    .req0   (port0Req),
    .req1   (port1Req),
    .busRsp (busRsp),
    .owner  (owner),
    .rsp0   (port0Rsp),
    .rsp1   (port1Rsp)
);

/* tb/aluSubsysTb.sv */
`timescale 1ns/1ps

module aluSubsysTb
    import aluPkg::*;
();

    // One trace line
    typedef struct packed {
        aluWord                  a;
        aluWord                  b;
        logic [funcBits-1:0]     func;
        aluWord                  res;
        logic [$bits(aluFlags)-1:0] flg;   // cond overflow carry negative zero
    } testVec;

    logic   clk;
    logic   rst;
    wbReq   port0Req;
    wbReq   port1Req;
    wbRsp   port0Rsp;
    wbRsp   port1Rsp;

    testVec tests0[$];    // Port 0 stream
    testVec tests1[$];    // Port 1 stream
    int     numTests;
    int     passCount;
    int     failCount;
    logic   traceReady;   // Starts the watchdog

    aluSubsys aluSubsys_i (
        .clk      (clk),
        .rst      (rst),
        .port0Req (port0Req),
        .port1Req (port1Req),
        .port0Rsp (port0Rsp),
        .port1Rsp (port1Rsp)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;    // 8 ns period

    // Fill both queues from the trace file
    task automatic readTrace();
        int                  fd;
        int                  nItems;
        int                  port;
        string               line;
        aluWord              a;
        aluWord              b;
        aluWord              res;
        logic [funcBits-1:0] f;
        logic [4:0]          fl;
        fd = $fopen("tb/aluTrace.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the trace file tb/aluTrace.txt");
            failCount++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                // Comment and blank lines give fewer than six items
                nItems = $sscanf(line, "%h %h %h %h %h %h", port, a, b, f, res, fl);
                if (nItems == 6)
                begin
                    if (port == 0)
                        tests0.push_back('{a: a, b: b, func: f, res: res, flg: fl});
                    else
                        tests1.push_back('{a: a, b: b, func: f, res: res, flg: fl});
                end
            end
            $fclose(fd);
        end
    endtask

    // Request lines change only on the rising edge
    task automatic setReq(input int port, input wbReq req);
        if (port == 0)
            port0Req <= req;
        else
            port1Req <= req;
    endtask

    // One Wishbone classic cycle, cyc dropped after ack
    task automatic transfer(input int port, input logic we, input regAddr adr,
                            input aluWord wdat, output aluWord rdat);
        wbReq req;
        logic ack;
        req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(posedge clk);
        setReq(port, req);
        ack = 1'b0;
        while (!ack)
        begin
            @(negedge clk);    // Response settled mid cycle
            ack  = (port == 0) ? port0Rsp.ack : port1Rsp.ack;
            rdat = (port == 0) ? port0Rsp.dat : port1Rsp.dat;
        end
        @(posedge clk);
        setReq(port, '0);
    endtask

    task automatic runTest(input int port, input int idx, input testVec tv);
        aluWord rdRes;
        aluWord rdFlg;
        aluWord unused;
        logic   ok;
        transfer(port, 1'b1, regOpA, tv.a, unused);
        transfer(port, 1'b1, regOpB, tv.b, unused);
        transfer(port, 1'b1, regFunc, aluWord'(tv.func), unused);
        transfer(port, 1'b0, regResult, '0, rdRes);
        transfer(port, 1'b0, regFlags, '0, rdFlg);
        ok = 1'b1;
        assert (rdRes == tv.res)
        else
        begin
            $display("Mismatch at time %0t: port %0d func %02h result expected %08h got %08h",
                     $time, port, tv.func, tv.res, rdRes);
            ok = 1'b0;
        end
        assert (rdFlg == aluWord'(tv.flg))
        else
        begin
            $display("Mismatch at time %0t: port %0d func %02h flags expected %02h got %02h",
                     $time, port, tv.func, tv.flg, rdFlg);
            ok = 1'b0;
        end
        if (ok)
            passCount++;
        else
            failCount++;
        $display("Port %0d test %0d func %02h: %s", port, idx, tv.func, ok ? "ok" : "FAILED");
    endtask

    // Walk one port's queue in order
    task automatic runPort(input int port);
        int     count;
        testVec tv;
        count = (port == 0) ? tests0.size() : tests1.size();
        for (int i = 0; i < count; i++)
        begin
            tv = (port == 0) ? tests0[i] : tests1[i];
            runTest(port, i, tv);
        end
    endtask

    initial
    begin
        rst        = 1'b1;
        port0Req   = '0;
        port1Req   = '0;
        numTests   = 0;
        passCount  = 0;
        failCount  = 0;
        traceReady = 1'b0;
        readTrace();
        numTests = tests0.size() + tests1.size();
        if (numTests == 0)
        begin
            $display("The trace file holds no tests");
            failCount++;
        end
        traceReady = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // Both masters contend for the slave
        fork
            runPort(0);
            runPort(1);
        join
        repeat (2) @(posedge clk);
        $display("Tests run %0d, ok %0d, failed %0d", passCount + failCount, passCount,
                 failCount);
        if (failCount == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // Tests times transfers times cycles times period
    initial
    begin
        int unsigned limitNs;
        wait (traceReady);
        limitNs = numTests * 5 * 20 * 8;
        #(limitNs);
        $display("Simulation timed out after %0d ns with transfers still open", limitNs);
        $display("Test failures found");
        $finish;
    end

endmodule

/* tb/aluTrace.txt */
# port opA opB func result flags, all hex
# flag bits from bit 4 down are cond overflow carry negative zero
0 f0f0ff00 0ff0f0f0 24 00f0f000 00
0 f0f00000 00000f0f 25 f0f00f0f 02
0 12345678 12345678 26 00000000 01
0 00000000 00000000 27 ffffffff 02
0 80000001 00000000 3f 80000001 02
0 0000abcd 00000001 0b 0000abcd 10
0 0000abcd 00000000 0b 00000000 01
0 0000abcd 00000000 0a 0000abcd 10
0 0000abcd 00000005 0a 00000000 01
0 ffffffff 00000001 21 00000000 05
0 7fffffff 00000001 20 80000000 0a
0 80000000 00000001 22 7fffffff 08
0 00000001 00000002 23 ffffffff 06
0 fffffffe fffffffe 20 fffffffc 06
0 00000005 00000005 22 00000000 01
0 00000007 00000000 0d 00000001 10
1 00000000 80000001 00 00000002 00
1 00000000 80000001 02 40000000 00
1 00000000 80000001 03 c0000000 02
1 ffffffe4 0000000f 04 000000f0 00
1 0000001f 80000000 06 00000001 00
1 00000008 f0000000 07 fff00000 02
1 ffffffff 00000000 1c 00000020 00
1 00000000 00000000 1d 00000020 00
1 fff00000 00000000 1c 0000000c 00
1 80000000 00000000 1d 00000000 01
1 0000ffff 00000000 1d 00000010 00
1 ffffffff 00000001 2a 00000001 10
1 ffffffff 00000001 2b 00000000 01
1 00001234 00001234 1f 00000001 10
1 00000001 ffffffff 0f 00000001 10
1 ffffffff 00000001 0f 00000000 01
1 80000000 00000000 0d 00000000 01

/* flist.f */
hw/aluPkg.sv
hw/leadCount.sv
hw/aluCore.sv
hw/wbArbiter.sv
hw/aluRegSlave.sv
hw/aluSubsys.sv
tb/aluSubsys_chk.sv
tb/aluSubsysTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the ALU subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module aluSubsysTb \
    --Mdir obj_dir -o aluSim \
    -f flist.f

# Verdict comes from the log
./obj_dir/aluSim | tee sim.log

if grep -qx 'All tests passed!' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
